//--- rename_map.f
+incdir+include
rtl/rename_pkg.sv
rtl/commit_pkg.sv
rtl/rename_alloc_decode.sv
rtl/rename_free_list.sv
rtl/rename_spec_map.sv
rtl/rename_commit_map.sv
rtl/rename_map_top.sv
verification/rename_map_assertions.sv
verification/rename_map_tb.sv

//--- Makefile
# Verilator build, run and lint for rename_map.

VERILATOR  ?= verilator
TOP        ?= rename_map_tb
FILELIST   ?= rename_map.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG   ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass message shows up in the output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/rename_map_tb.sv
// ------------------------------------------------------------
// Rename map testbench
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "rename_params.svh"

module rename_map_tb;

  localparam rename_pkg::reg_typ_t GPR = rename_pkg::GPR;
  localparam rename_pkg::reg_typ_t FPR = rename_pkg::FPR;
  // About 300 cycles of tests plus reset and a wide margin.
  localparam int TIMEOUT_CYCLES = 2000;

  // One allocated destination still waiting for commit.
  typedef struct packed {
    rename_pkg::reg_typ_t typ;
    rename_pkg::regidx_t  rd;
    rename_pkg::rnid_t    rnid;
  } flight_t;

  logic                      i_clk;
  logic                      i_reset_n;
  rename_pkg::disp_grp_t     i_disp;
  commit_pkg::cmt_rnid_upd_t i_commit;
  rename_pkg::rename_res_t   o_rename;
  logic                      o_ready;

  // Reference model, indexed by class.
  int smap [2][`RN_ARCH_REGS];
  int cmap [2][`RN_ARCH_REGS];
  // Free list as an unbounded log that never wraps.
  int fl_mem [2][0:1023];
  int fl_spec [2];
  int fl_cmt [2];
  int fl_tail [2];
  flight_t inflight [$];

  int          err_cnt = 0;
  int          check_cnt = 0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_state = 32'd77586;

  rename_map_top i_rename_map_top (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_disp    (i_disp),
    .i_commit  (i_commit),
    .o_rename  (o_rename),
    .o_ready   (o_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [4:0] rand_reg();
    logic [4:0] v;
    v = '0;
    for (int b = 0; b < 5; b++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      v[b] = lfsr_state[0];
    end
    return v;
  endfunction

  function automatic int rand_nz();
    logic [4:0] v;
    v = rand_reg();
    return (v == 5'd0) ? 1 : int'(v);
  endfunction

  function automatic rename_pkg::disp_slot_t make_slot(
    input logic rd_valid, input rename_pkg::reg_typ_t rd_typ, input int rd,
    input rename_pkg::reg_typ_t rs1_typ, input int rs1,
    input rename_pkg::reg_typ_t rs2_typ, input int rs2);
    rename_pkg::disp_slot_t s;
    s.valid      = 1'b1;
    s.rd_valid   = rd_valid;
    s.rd_typ     = rd_typ;
    s.rd_regidx  = rename_pkg::regidx_t'(rd);
    s.rs1_typ    = rs1_typ;
    s.rs1_regidx = rename_pkg::regidx_t'(rs1);
    s.rs2_typ    = rs2_typ;
    s.rs2_regidx = rename_pkg::regidx_t'(rs2);
    return s;
  endfunction

  function automatic int free_cnt(input int t);
    return fl_tail[t] - fl_spec[t];
  endfunction

  function automatic logic ready_exp();
    return (free_cnt(0) >= `RN_DISP_SIZE) && (free_cnt(1) >= `RN_DISP_SIZE);
  endfunction

  // Map value seen by a slot, after older slots of the group.
  function automatic int lookup(input rename_pkg::disp_grp_t grp,
                                input logic alloc [`RN_DISP_SIZE],
                                input int new_rnid [`RN_DISP_SIZE], input int slot,
                                input rename_pkg::reg_typ_t typ,
                                input rename_pkg::regidx_t idx);
    int r;
    r = smap[int'(typ)][idx];
    for (int j = 0; j < slot; j++) begin
      if (alloc[j] && (grp[j].rd_typ == typ) && (grp[j].rd_regidx == idx)) begin
        r = new_rnid[j];
      end
    end
    return r;
  endfunction

  task automatic model_reset();
    for (int t = 0; t < 2; t++) begin
      for (int r = 0; r < `RN_ARCH_REGS; r++) begin
        smap[t][r] = r;
        cmap[t][r] = r;
      end
      for (int e = 0; e < `RN_RNID_SIZE - `RN_ARCH_REGS; e++) begin
        fl_mem[t][e] = `RN_ARCH_REGS + e;
      end
      fl_spec[t] = 0;
      fl_cmt[t]  = 0;
      fl_tail[t] = `RN_RNID_SIZE - `RN_ARCH_REGS;
    end
    inflight.delete();
  endtask

  task automatic check_val(input string name, input int actual, input int expected);
    check_cnt++;
    assert (actual == expected) else begin
      err_cnt++;
      $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  // Drive one group, check rename results, then track the allocations.
  task automatic dispatch_group(input rename_pkg::disp_grp_t grp);
    logic    exp_ready;
    logic    alloc [`RN_DISP_SIZE];
    int      new_rnid [`RN_DISP_SIZE];
    int      taken [2];
    int      t;
    int      exp_old;
    flight_t f;
    @(negedge i_clk);
    i_disp   = grp;
    i_commit = '0;
    #1;
    exp_ready = ready_exp();
    check_val("o_ready", int'(o_ready), int'(exp_ready));
    taken = '{0, 0};
    for (int i = 0; i < `RN_DISP_SIZE; i++) begin
      t = int'(grp[i].rd_typ);
      // x0 and a stalled group take nothing.
      alloc[i] = exp_ready && grp[i].valid && grp[i].rd_valid &&
                 !((grp[i].rd_typ == GPR) && (grp[i].rd_regidx == '0));
      new_rnid[i] = alloc[i] ? fl_mem[t][fl_spec[t] + taken[t]] : 0;
      if (alloc[i]) begin
        taken[t]++;
      end
      if (grp[i].valid) begin
        exp_old = lookup(grp, alloc, new_rnid, i, grp[i].rd_typ, grp[i].rd_regidx);
        check_val($sformatf("slot%0d old_rd_rnid", i), int'(o_rename.old_rd_rnid[i]), exp_old);
        check_val($sformatf("slot%0d rd_rnid", i), int'(o_rename.rd_rnid[i]),
                  alloc[i] ? new_rnid[i] : exp_old);
        check_val($sformatf("slot%0d rs1_rnid", i), int'(o_rename.rs1_rnid[i]),
                  lookup(grp, alloc, new_rnid, i, grp[i].rs1_typ, grp[i].rs1_regidx));
        check_val($sformatf("slot%0d rs2_rnid", i), int'(o_rename.rs2_rnid[i]),
                  lookup(grp, alloc, new_rnid, i, grp[i].rs2_typ, grp[i].rs2_regidx));
      end
    end
    @(posedge i_clk);
    // Slot order, so the younger write wins.
    for (int i = 0; i < `RN_DISP_SIZE; i++) begin
      if (alloc[i]) begin
        t = int'(grp[i].rd_typ);
        smap[t][grp[i].rd_regidx] = new_rnid[i];
        fl_spec[t]++;
        f.typ  = grp[i].rd_typ;
        f.rd   = grp[i].rd_regidx;
        f.rnid = rename_pkg::rnid_t'(new_rnid[i]);
        inflight.push_back(f);
      end
    end
  endtask

  // Retire the n oldest allocations, then wait for their releases.
  task automatic commit_group(input int n, input logic [`RN_DISP_SIZE-1:0] dead,
                              input logic [`RN_DISP_SIZE-1:0] exc,
                              input commit_pkg::except_t etype);
    commit_pkg::cmt_rnid_upd_t c;
    flight_t                   f;
    int                        rel_typ [`RN_DISP_SIZE];
    int                        rel_rnid [`RN_DISP_SIZE];
    logic                      flush;
    logic                      is_dead;
    c = '0;
    c.commit = 1'b1;
    for (int i = 0; i < n; i++) begin
      c.rnid_valid[i] = 1'b1;
      c.rd_typ[i]     = inflight[i].typ;
      c.rd_regidx[i]  = inflight[i].rd;
      c.rd_rnid[i]    = inflight[i].rnid;
    end
    c.dead_id      = dead;
    c.except_valid = exc;
    c.except_type  = etype;
    flush = |exc;
    @(negedge i_clk);
    i_disp   = '0;
    i_commit = c;
    #1;
    check_val("o_ready", int'(o_ready), flush ? 0 : int'(ready_exp()));
    @(posedge i_clk);
    for (int i = 0; i < n; i++) begin
      f = inflight.pop_front();
      is_dead = dead[i] || (exc[i] && (etype != commit_pkg::EXC_SILENT_FLUSH));
      rel_typ[i] = int'(f.typ);
      if (is_dead) begin
        rel_rnid[i] = int'(f.rnid);
      end else begin
        rel_rnid[i] = cmap[rel_typ[i]][f.rd];
        cmap[rel_typ[i]][f.rd] = int'(f.rnid);
      end
      fl_cmt[rel_typ[i]]++;
    end
    if (flush) begin
      smap = cmap;
      fl_spec = fl_cmt;
      inflight.delete();
    end
    @(negedge i_clk);
    i_commit = '0;
    // Releases reach the tail one edge later.
    @(posedge i_clk);
    for (int i = 0; i < n; i++) begin
      fl_mem[rel_typ[i]][fl_tail[rel_typ[i]]] = rel_rnid[i];
      fl_tail[rel_typ[i]]++;
    end
  endtask

  // Looks up every register of both classes.
  task automatic check_all_sources();
    rename_pkg::disp_grp_t grp;
    for (int k = 0; k < `RN_ARCH_REGS / 2; k++) begin
      grp[0] = make_slot(1'b0, GPR, 0, GPR, k, FPR, k);
      grp[1] = make_slot(1'b0, GPR, 0, FPR, k + 16, GPR, k + 16);
      dispatch_group(grp);
    end
  endtask

  task automatic test_reset_map();
    check_all_sources();
  endtask

  task automatic test_rename_chain();
    rename_pkg::disp_grp_t grp;
    int a;
    int b;
    for (int g = 0; g < 6; g++) begin
      a = int'(rand_reg());
      b = int'(rand_reg());
      // Slot 1 reads slot 0's destination.
      grp[0] = make_slot(1'b1, GPR, a, GPR, b, FPR, a);
      grp[1] = make_slot(1'b1, FPR, b, GPR, a, FPR, b);
      dispatch_group(grp);
    end
    grp[0] = make_slot(1'b1, GPR, 0, GPR, 5, GPR, 0);
    grp[1] = make_slot(1'b1, GPR, 7, GPR, 0, FPR, 7);
    dispatch_group(grp);
    // Same rd twice.
    grp[0] = make_slot(1'b1, GPR, 9, GPR, 9, FPR, 9);
    grp[1] = make_slot(1'b1, GPR, 9, GPR, 9, GPR, 7);
    dispatch_group(grp);
  endtask

  task automatic test_commit_flush();
    rename_pkg::disp_grp_t grp;
    commit_group(2, 2'b00, 2'b00, commit_pkg::EXC_SILENT_FLUSH);
    commit_group(2, 2'b00, 2'b00, commit_pkg::EXC_SILENT_FLUSH);
    commit_group(1, 2'b00, 2'b01, commit_pkg::EXC_TRAP);
    check_all_sources();
    grp[0] = make_slot(1'b1, GPR, 20, GPR, 20, FPR, 21);
    grp[1] = make_slot(1'b1, FPR, 21, GPR, 20, FPR, 21);
    dispatch_group(grp);
    commit_group(2, 2'b00, 2'b00, commit_pkg::EXC_SILENT_FLUSH);
  endtask

  task automatic test_record_rule();
    rename_pkg::disp_grp_t grp;
    grp[0] = make_slot(1'b1, GPR, 3, GPR, 1, GPR, 2);
    grp[1] = make_slot(1'b1, FPR, 4, FPR, 1, FPR, 2);
    dispatch_group(grp);
    grp[0] = make_slot(1'b1, GPR, 5, GPR, 3, FPR, 4);
    grp[1] = make_slot(1'b1, GPR, 6, GPR, 5, GPR, 3);
    dispatch_group(grp);
    grp[0] = make_slot(1'b1, FPR, 8, FPR, 4, GPR, 6);
    grp[1] = make_slot(1'b1, GPR, 3, GPR, 6, FPR, 8);
    dispatch_group(grp);
    // Dead slot 1 is dropped.
    commit_group(2, 2'b10, 2'b00, commit_pkg::EXC_SILENT_FLUSH);
    // Replay kills slot 0 and flushes the third group.
    commit_group(2, 2'b00, 2'b01, commit_pkg::EXC_REPLAY);
    check_all_sources();
    grp[0] = make_slot(1'b1, GPR, 10, GPR, 5, GPR, 6);
    grp[1] = make_slot(1'b1, FPR, 11, FPR, 4, FPR, 8);
    dispatch_group(grp);
    // Silent flush keeps slot 1.
    commit_group(2, 2'b00, 2'b10, commit_pkg::EXC_SILENT_FLUSH);
    check_all_sources();
  endtask

  task automatic test_recycle();
    rename_pkg::disp_grp_t grp;
    int a;
    int b;
    // Enough traffic to wrap both queues.
    for (int g = 0; g < 40; g++) begin
      a = int'(rand_reg());
      b = int'(rand_reg());
      grp[0] = make_slot(1'b1, GPR, a, GPR, b, FPR, a);
      grp[1] = make_slot(1'b1, FPR, b, FPR, a, GPR, a);
      dispatch_group(grp);
      if (inflight.size() > 0) begin
        commit_group(inflight.size(), 2'b00, 2'b00, commit_pkg::EXC_SILENT_FLUSH);
      end
    end
    // Drain GPR entries down to one.
    while (free_cnt(0) > 1) begin
      a = rand_nz();
      b = rand_nz();
      grp[0] = make_slot(1'b1, GPR, a, GPR, b, GPR, a);
      grp[1] = make_slot(free_cnt(0) >= 3, GPR, b, GPR, a, FPR, b);
      dispatch_group(grp);
    end
    // Ignored while stalled.
    grp[0] = make_slot(1'b1, GPR, 12, GPR, 12, FPR, 13);
    grp[1] = make_slot(1'b1, FPR, 13, GPR, 12, FPR, 13);
    dispatch_group(grp);
    check_all_sources();
    commit_group(1, 2'b00, 2'b01, commit_pkg::EXC_TRAP);
    dispatch_group(grp);
    check_all_sources();
  endtask

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", check_cnt, err_cnt + 1);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    i_reset_n = 1'b0;
    i_disp    = '0;
    i_commit  = '0;
    model_reset();
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    test_reset_map();
    test_rename_chain();
    test_commit_flush();
    test_record_rule();
    test_recycle();
    @(negedge i_clk);
    // Bound assertion failures count as errors.
    err_cnt += i_rename_map_top.u_rename_map_assertions.fail_cnt;
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verification/rename_map_assertions.sv
// ------------------------------------------------------------
// Rename map assertions
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "rename_params.svh"

module rename_map_assertions (
  input logic                      i_clk,
  input logic                      i_reset_n,
  input rename_pkg::disp_grp_t     i_disp,
  input commit_pkg::cmt_rnid_upd_t i_commit,
  input rename_pkg::rename_res_t   o_rename,
  input logic                      o_ready
);

  // Number of failed assertions.
  int fail_cnt = 0;

  // Dispatch open right out of reset.
  ready_after_reset: assert property (@(posedge i_clk) $rose(i_reset_n) |-> o_ready)
    else begin
      fail_cnt++;
      $error("o_ready low in the first cycle after reset");
    end

  // Flush commit blocks dispatch.
  ready_low_on_flush: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (i_commit.commit && (|i_commit.except_valid)) |-> !o_ready)
    else begin
      fail_cnt++;
      $error("o_ready high during a flush commit");
    end

  // x0 sources always read rnid 0.
  for (genvar i = 0; i < `RN_DISP_SIZE; i++) begin : g_x0
    x0_rs1: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        ((i_disp[i].rs1_typ == rename_pkg::GPR) && (i_disp[i].rs1_regidx == '0)) |->
        (o_rename.rs1_rnid[i] == '0))
      else begin
        fail_cnt++;
        $error("GPR x0 rs1 renamed to a nonzero rnid");
      end
    x0_rs2: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        ((i_disp[i].rs2_typ == rename_pkg::GPR) && (i_disp[i].rs2_regidx == '0)) |->
        (o_rename.rs2_rnid[i] == '0))
      else begin
        fail_cnt++;
        $error("GPR x0 rs2 renamed to a nonzero rnid");
      end
  end

endmodule

bind rename_map_top rename_map_assertions u_rename_map_assertions (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_disp    (i_disp),
  .i_commit  (i_commit),
  .o_rename  (o_rename),
  .o_ready   (o_ready)
);

//--- rtl/rename_map_top.sv
// ------------------------------------------------------------
// Register rename map top
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "rename_params.svh"

module rename_map_top (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  rename_pkg::disp_grp_t     i_disp,
  input  commit_pkg::cmt_rnid_upd_t i_commit,
  output rename_pkg::rename_res_t   o_rename,
  output logic                      o_ready
);

  rename_pkg::alloc_req_t                w_gpr_alloc;
  rename_pkg::alloc_req_t                w_fpr_alloc;
  logic                                  w_gpr_enough;
  logic                                  w_fpr_enough;
  rename_pkg::rnid_t [`RN_DISP_SIZE-1:0] w_gpr_new_rnid;
  rename_pkg::rnid_t [`RN_DISP_SIZE-1:0] w_fpr_new_rnid;
  rename_pkg::rnid_t                     w_gpr_cmt_map [`RN_ARCH_REGS];
  rename_pkg::rnid_t                     w_fpr_cmt_map [`RN_ARCH_REGS];
  logic                                  w_gpr_flush;
  logic                                  w_fpr_flush;
  commit_pkg::release_t                  w_gpr_release;
  commit_pkg::release_t                  w_fpr_release;
  rename_pkg::rename_res_t               w_gpr_rename;
  rename_pkg::rename_res_t               w_fpr_rename;

  rename_alloc_decode u_alloc_decode (
    .i_disp       (i_disp),
    .i_commit     (i_commit),
    .i_gpr_enough (w_gpr_enough),
    .i_fpr_enough (w_fpr_enough),
    .o_gpr_alloc  (w_gpr_alloc),
    .o_fpr_alloc  (w_fpr_alloc),
    .o_ready      (o_ready)
  );

  // GPR class.
  rename_free_list #(.REG_TYPE(rename_pkg::GPR)) u_gpr_free_list (
    .i_clk, .i_reset_n, .i_alloc(w_gpr_alloc), .i_commit,
    .i_release(w_gpr_release), .o_new_rnid(w_gpr_new_rnid), .o_enough(w_gpr_enough)
  );
  rename_spec_map #(.REG_TYPE(rename_pkg::GPR)) u_gpr_spec_map (
    .i_clk, .i_reset_n, .i_disp, .i_alloc(w_gpr_alloc), .i_new_rnid(w_gpr_new_rnid),
    .i_commit_map_next(w_gpr_cmt_map), .i_flush(w_gpr_flush), .o_rename(w_gpr_rename)
  );
  rename_commit_map #(.REG_TYPE(rename_pkg::GPR)) u_gpr_commit_map (
    .i_clk, .i_reset_n, .i_commit, .o_commit_map_next(w_gpr_cmt_map),
    .o_flush(w_gpr_flush), .o_release(w_gpr_release)
  );

  // FPR class.
  rename_free_list #(.REG_TYPE(rename_pkg::FPR)) u_fpr_free_list (
    .i_clk, .i_reset_n, .i_alloc(w_fpr_alloc), .i_commit,
    .i_release(w_fpr_release), .o_new_rnid(w_fpr_new_rnid), .o_enough(w_fpr_enough)
  );
  rename_spec_map #(.REG_TYPE(rename_pkg::FPR)) u_fpr_spec_map (
    .i_clk, .i_reset_n, .i_disp, .i_alloc(w_fpr_alloc), .i_new_rnid(w_fpr_new_rnid),
    .i_commit_map_next(w_fpr_cmt_map), .i_flush(w_fpr_flush), .o_rename(w_fpr_rename)
  );
  rename_commit_map #(.REG_TYPE(rename_pkg::FPR)) u_fpr_commit_map (
    .i_clk, .i_reset_n, .i_commit, .o_commit_map_next(w_fpr_cmt_map),
    .o_flush(w_fpr_flush), .o_release(w_fpr_release)
  );

  // Each operand takes its own class's result.
  for (genvar i = 0; i < `RN_DISP_SIZE; i++) begin : g_merge
    assign o_rename.rd_rnid[i] = (i_disp[i].rd_typ == rename_pkg::GPR) ?
                                 w_gpr_rename.rd_rnid[i] : w_fpr_rename.rd_rnid[i];
    assign o_rename.old_rd_rnid[i] = (i_disp[i].rd_typ == rename_pkg::GPR) ?
                                     w_gpr_rename.old_rd_rnid[i] :
                                     w_fpr_rename.old_rd_rnid[i];
    assign o_rename.rs1_rnid[i] = (i_disp[i].rs1_typ == rename_pkg::GPR) ?
                                  w_gpr_rename.rs1_rnid[i] : w_fpr_rename.rs1_rnid[i];
    assign o_rename.rs2_rnid[i] = (i_disp[i].rs2_typ == rename_pkg::GPR) ?
                                  w_gpr_rename.rs2_rnid[i] : w_fpr_rename.rs2_rnid[i];
  end

endmodule

//--- rtl/rename_commit_map.sv
// ------------------------------------------------------------
// Committed rename map
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "rename_params.svh"

module rename_commit_map #(
  parameter rename_pkg::reg_typ_t REG_TYPE = rename_pkg::GPR
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  commit_pkg::cmt_rnid_upd_t i_commit,
  output rename_pkg::rnid_t         o_commit_map_next [`RN_ARCH_REGS],
  output logic                      o_flush,
  output commit_pkg::release_t      o_release
);

  rename_pkg::rnid_t r_map [`RN_ARCH_REGS];
  rename_pkg::rnid_t w_map_next [`RN_ARCH_REGS];

  logic [`RN_DISP_SIZE-1:0]                      w_mine;
  logic [`RN_DISP_SIZE-1:0]                      w_dead;
  logic [`RN_DISP_SIZE-1:0]                      w_record;
  commit_pkg::release_t                          w_release;
  logic [`RN_DISP_SIZE-1:0]                      r_rel_valid;
  rename_pkg::rnid_t [`RN_DISP_SIZE-1:0]         r_rel_rnid;

  assign o_flush = i_commit.commit & (|i_commit.except_valid);

  always_comb begin
    w_map_next = r_map;
    w_release  = '0;
    for (int i = 0; i < `RN_DISP_SIZE; i++) begin
      // Committed destination of this class.
      w_mine[i] = i_commit.commit & i_commit.rnid_valid[i] &
                  (i_commit.rd_typ[i] == REG_TYPE);
      // Only a silent flush keeps the excepting slot alive.
      w_dead[i] = i_commit.dead_id[i] |
                  (i_commit.except_valid[i] &
                   (i_commit.except_type != commit_pkg::EXC_SILENT_FLUSH));
      w_record[i] = w_mine[i] & !w_dead[i] &
                    !((REG_TYPE == rename_pkg::GPR) && (i_commit.rd_regidx[i] == '0));

      if (w_record[i]) begin
        // Free the mapping being replaced.
        // Sees slot 0's write when both hit the same rd.
        w_release.valid[i] = 1'b1;
        w_release.rnid[i]  = w_map_next[i_commit.rd_regidx[i]];
        w_map_next[i_commit.rd_regidx[i]] = i_commit.rd_rnid[i];
      end else if (w_mine[i] && w_dead[i]) begin
        // Never became architectural, give back its own rnid.
        w_release.valid[i] = 1'b1;
        w_release.rnid[i]  = i_commit.rd_rnid[i];
      end
    end
  end

  assign o_commit_map_next = w_map_next;

  for (genvar r = 0; r < `RN_ARCH_REGS; r++) begin : g_map
    if ((REG_TYPE == rename_pkg::GPR) && (r == 0)) begin : g_x0
      assign r_map[r] = '0;
    end else begin : g_reg
      always_ff @(posedge i_clk, negedge i_reset_n) begin
        if (!i_reset_n) begin
          r_map[r] <= rename_pkg::rnid_t'(r);
        end else begin
          r_map[r] <= w_map_next[r];
        end
      end
    end
  end

  // Release goes out one cycle after the commit strobe.
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rel_valid <= '0;
    end else begin
      r_rel_valid <= w_release.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rel_rnid <= w_release.rnid;
  end

  assign o_release.valid = r_rel_valid;
  assign o_release.rnid  = r_rel_rnid;

endmodule

//--- rtl/rename_spec_map.sv
// ------------------------------------------------------------
// Speculative rename map
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "rename_params.svh"

module rename_spec_map #(
  parameter rename_pkg::reg_typ_t REG_TYPE = rename_pkg::GPR
) (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,
  input  rename_pkg::disp_grp_t                 i_disp,
  input  rename_pkg::alloc_req_t                i_alloc,
  input  rename_pkg::rnid_t [`RN_DISP_SIZE-1:0] i_new_rnid,
  input  rename_pkg::rnid_t                     i_commit_map_next [`RN_ARCH_REGS],
  input  logic                                  i_flush,
  output rename_pkg::rename_res_t               o_rename
);

  rename_pkg::rnid_t r_map [`RN_ARCH_REGS];
  rename_pkg::rnid_t w_map_next [`RN_ARCH_REGS];

  // Lookups in this class's map.
  // The top picks the class per operand.
  always_comb begin
    for (int i = 0; i < `RN_DISP_SIZE; i++) begin
      o_rename.rs1_rnid[i]    = r_map[i_disp[i].rs1_regidx];
      o_rename.rs2_rnid[i]    = r_map[i_disp[i].rs2_regidx];
      o_rename.old_rd_rnid[i] = r_map[i_disp[i].rd_regidx];

      // Older slots in the group win over the map.
      // Youngest older writer wins.
      for (int j = 0; j < i; j++) begin
        if (i_alloc.valid[j] && (i_disp[j].rd_regidx == i_disp[i].rs1_regidx)) begin
          o_rename.rs1_rnid[i] = i_new_rnid[j];
        end
        if (i_alloc.valid[j] && (i_disp[j].rd_regidx == i_disp[i].rs2_regidx)) begin
          o_rename.rs2_rnid[i] = i_new_rnid[j];
        end
        if (i_alloc.valid[j] && (i_disp[j].rd_regidx == i_disp[i].rd_regidx)) begin
          o_rename.old_rd_rnid[i] = i_new_rnid[j];
        end
      end

      // Without allocation rd keeps its current mapping, 0 for x0.
      o_rename.rd_rnid[i] = i_alloc.valid[i] ? i_new_rnid[i] : o_rename.old_rd_rnid[i];
    end
  end

  // Next map.
  always_comb begin
    w_map_next = r_map;
    if (i_flush) begin
      // Roll back to the committed state.
      w_map_next = i_commit_map_next;
    end else begin
      // Slot order, so slot 1 wins on the same rd.
      for (int i = 0; i < `RN_DISP_SIZE; i++) begin
        if (i_alloc.valid[i]) begin
          w_map_next[i_disp[i].rd_regidx] = i_new_rnid[i];
        end
      end
    end
  end

  for (genvar r = 0; r < `RN_ARCH_REGS; r++) begin : g_map
    if ((REG_TYPE == rename_pkg::GPR) && (r == 0)) begin : g_x0
      // x0 is tied to rnid 0.
      assign r_map[r] = '0;
    end else begin : g_reg
      always_ff @(posedge i_clk, negedge i_reset_n) begin
        if (!i_reset_n) begin
          r_map[r] <= rename_pkg::rnid_t'(r);
        end else begin
          r_map[r] <= w_map_next[r];
        end
      end
    end
  end

endmodule

//--- rtl/rename_free_list.sv
// ------------------------------------------------------------
// Rename free list
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "rename_params.svh"

module rename_free_list #(
  parameter rename_pkg::reg_typ_t REG_TYPE = rename_pkg::GPR
) (
  input  logic                                        i_clk,
  input  logic                                        i_reset_n,
  input  rename_pkg::alloc_req_t                      i_alloc,
  input  commit_pkg::cmt_rnid_upd_t                   i_commit,
  input  commit_pkg::release_t                        i_release,
  output rename_pkg::rnid_t [`RN_DISP_SIZE-1:0]       o_new_rnid,
  output logic                                        o_enough
);

  localparam int DEPTH = `RN_RNID_SIZE - `RN_ARCH_REGS;
  localparam int IDX_W = $clog2(DEPTH);
  // One extra wrap bit tells full from empty.
  localparam int PTR_W = IDX_W + 1;
  localparam int CNT_W = $clog2(`RN_DISP_SIZE + 1);

  rename_pkg::rnid_t r_entries [DEPTH];

  logic [PTR_W-1:0] r_spec_head;
  logic [PTR_W-1:0] r_cmt_head;
  logic [PTR_W-1:0] r_tail;
  logic [PTR_W-1:0] w_cmt_head_next;
  logic [PTR_W-1:0] w_free_cnt;
  logic [PTR_W-1:0] w_alloc_ptr [`RN_DISP_SIZE];
  logic [PTR_W-1:0] w_push_ptr [`RN_DISP_SIZE];
  logic [CNT_W-1:0] w_alloc_cnt;
  logic [CNT_W-1:0] w_push_cnt;
  logic [CNT_W-1:0] w_cmt_cnt;
  logic             w_flush;

  assign w_flush = i_commit.commit & (|i_commit.except_valid);

  always_comb begin
    w_alloc_cnt = '0;
    w_push_cnt  = '0;
    w_cmt_cnt   = '0;
    for (int i = 0; i < `RN_DISP_SIZE; i++) begin
      // Slot pointers skip entries taken by older slots.
      w_alloc_ptr[i] = r_spec_head + PTR_W'(w_alloc_cnt);
      w_push_ptr[i]  = r_tail + PTR_W'(w_push_cnt);
      o_new_rnid[i]  = r_entries[w_alloc_ptr[i][IDX_W-1:0]];

      w_alloc_cnt = w_alloc_cnt + CNT_W'(i_alloc.valid[i]);
      w_push_cnt  = w_push_cnt + CNT_W'(i_release.valid[i]);
      // Dead slots count too; their rnid left the list at dispatch.
      if (i_commit.commit && i_commit.rnid_valid[i] &&
          (i_commit.rd_typ[i] == REG_TYPE)) begin
        w_cmt_cnt = w_cmt_cnt + 1'b1;
      end
    end
  end

  assign w_cmt_head_next = r_cmt_head + PTR_W'(w_cmt_cnt);

  // Entries between spec head and tail are free.
  assign w_free_cnt = r_tail - r_spec_head;
  assign o_enough   = w_free_cnt >= PTR_W'(`RN_DISP_SIZE);

  // Pointer state.
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_spec_head <= '0;
      r_cmt_head  <= '0;
      r_tail      <= PTR_W'(DEPTH);
    end else begin
      r_cmt_head <= w_cmt_head_next;
      r_tail     <= r_tail + PTR_W'(w_push_cnt);
      // Flush drops all uncommitted allocations.
      if (w_flush) begin
        r_spec_head <= w_cmt_head_next;
      end else begin
        r_spec_head <= r_spec_head + PTR_W'(w_alloc_cnt);
      end
    end
  end

  // Queue starts with the rnids above the reset mapping.
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < DEPTH; e++) begin
        r_entries[e] <= rename_pkg::rnid_t'(`RN_ARCH_REGS + e);
      end
    end else begin
      for (int i = 0; i < `RN_DISP_SIZE; i++) begin
        if (i_release.valid[i]) begin
          r_entries[w_push_ptr[i][IDX_W-1:0]] <= i_release.rnid[i];
        end
      end
    end
  end

endmodule

//--- rtl/rename_alloc_decode.sv
// ------------------------------------------------------------
// Rename allocation decode
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "rename_params.svh"

module rename_alloc_decode (
  input  rename_pkg::disp_grp_t     i_disp,
  input  commit_pkg::cmt_rnid_upd_t i_commit,
  input  logic                      i_gpr_enough,
  input  logic                      i_fpr_enough,
  output rename_pkg::alloc_req_t    o_gpr_alloc,
  output rename_pkg::alloc_req_t    o_fpr_alloc,
  output logic                      o_ready
);

  logic                     w_flush;
  logic [`RN_DISP_SIZE-1:0] w_rd_alloc;

  // Any excepting slot in a commit group flushes.
  assign w_flush = i_commit.commit & (|i_commit.except_valid);

  // Dispatch stalls on a flush or a short free list.
  // Either class can hold the group back.
  assign o_ready = !w_flush & i_gpr_enough & i_fpr_enough;

  always_comb begin
    for (int i = 0; i < `RN_DISP_SIZE; i++) begin
      // Destination needs a fresh rnid.
      // x0 is hardwired and never allocates.
      w_rd_alloc[i] = i_disp[i].valid & i_disp[i].rd_valid &
                      !((i_disp[i].rd_typ == rename_pkg::GPR) &&
                        (i_disp[i].rd_regidx == '0));

      // Split by class, dropped when not ready.
      o_gpr_alloc.valid[i] = o_ready & w_rd_alloc[i] &
                             (i_disp[i].rd_typ == rename_pkg::GPR);
      o_fpr_alloc.valid[i] = o_ready & w_rd_alloc[i] &
                             (i_disp[i].rd_typ == rename_pkg::FPR);
    end
  end

endmodule

//--- rtl/commit_pkg.sv
// ------------------------------------------------------------
// Commit types
// ------------------------------------------------------------
`include "rename_params.svh"

package commit_pkg;

  // Exception kind of a commit group.
  // A silent flush still retires the excepting instruction.
  typedef enum logic [1:0] {
    EXC_SILENT_FLUSH = 2'd0,
    EXC_REPLAY       = 2'd1,
    EXC_TRAP         = 2'd2
  } except_t;

  // Commit notification, one strobe per group.
  typedef struct packed {
    logic                                           commit;
    logic                     [`RN_DISP_SIZE-1:0]   rnid_valid;
    rename_pkg::reg_typ_t     [`RN_DISP_SIZE-1:0]   rd_typ;
    rename_pkg::regidx_t      [`RN_DISP_SIZE-1:0]   rd_regidx;
    rename_pkg::rnid_t        [`RN_DISP_SIZE-1:0]   rd_rnid;
    logic                     [`RN_DISP_SIZE-1:0]   dead_id;
    logic                     [`RN_DISP_SIZE-1:0]   except_valid;
    except_t                                        except_type;
  } cmt_rnid_upd_t;

  // Rnids going back to one class's free list.
  // Valid slots are pushed in slot order.
  typedef struct packed {
    logic              [`RN_DISP_SIZE-1:0] valid;
    rename_pkg::rnid_t [`RN_DISP_SIZE-1:0] rnid;
  } release_t;

endpackage

//--- rtl/rename_pkg.sv
// ------------------------------------------------------------
// Rename types
// ------------------------------------------------------------
`include "rename_params.svh"

package rename_pkg;

  // Register class.
  typedef enum logic {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_typ_t;

  localparam int RNID_W   = $clog2(`RN_RNID_SIZE);
  localparam int REGIDX_W = $clog2(`RN_ARCH_REGS);

  typedef logic [RNID_W-1:0]   rnid_t;
  typedef logic [REGIDX_W-1:0] regidx_t;

  // One dispatched instruction.
  typedef struct packed {
    logic     valid;
    logic     rd_valid;
    reg_typ_t rd_typ;
    regidx_t  rd_regidx;
    reg_typ_t rs1_typ;
    regidx_t  rs1_regidx;
    reg_typ_t rs2_typ;
    regidx_t  rs2_regidx;
  } disp_slot_t;

  // Slot 0 is the oldest in the group.
  typedef disp_slot_t [`RN_DISP_SIZE-1:0] disp_grp_t;

  // Rename result, one rnid of each kind per slot.
  typedef struct packed {
    rnid_t [`RN_DISP_SIZE-1:0] rd_rnid;
    rnid_t [`RN_DISP_SIZE-1:0] old_rd_rnid;
    rnid_t [`RN_DISP_SIZE-1:0] rs1_rnid;
    rnid_t [`RN_DISP_SIZE-1:0] rs2_rnid;
  } rename_res_t;

  // Allocation mask of one class.
  typedef struct packed {
    logic [`RN_DISP_SIZE-1:0] valid;
  } alloc_req_t;

endpackage

//--- include/rename_params.svh
// ------------------------------------------------------------
// Rename map parameters
// ------------------------------------------------------------
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Instructions per dispatch group.
// The commit group has the same width.
`define RN_DISP_SIZE 2

// Architectural registers in each class.
// Both GPR and FPR have 32 entries.
`define RN_ARCH_REGS 32

// Physical rnids in each class.
// The first RN_ARCH_REGS rnids hold the reset mapping,
// and the rest start out in the free list.
`define RN_RNID_SIZE 64

`endif
